// File: sources.f
src/ifq_pkg.sv
src/ifq_line_fifo.sv
src/ifq_fetch_ctrl.sv
src/ifq_instr_select.sv
src/ifq.sv
test/ifq_clk_gen.sv
test/ifq_checker.sv
test/ifq_tb.sv

// File: Bender.yml
package:
  name: ifq

sources:
  # package first, top level last
  - src/ifq_pkg.sv
  - src/ifq_line_fifo.sv
  - src/ifq_fetch_ctrl.sv
  - src/ifq_instr_select.sv
  - src/ifq.sv

  - target: test
    files:
      - test/ifq_clk_gen.sv
      - test/ifq_checker.sv
      - test/ifq_tb.sv

// File: test/ifq_golden.txt
// columns: opcode _ argument a _ argument b, all hex. opcodes: 01 pattern key a,
// 02 latency a to b, 03 redirect to a, 04 read a instructions, 05 stall a cycles, 00 end
01_5a3c96e1_0000  // pattern key, instr = pc ^ key
02_00000002_0005  // latency 2 to 5 cycles
04_00000018_0000  // 24 reads from address 0
05_00000005_0000
04_00000009_0000
03_00001008_0000  // unaligned target
04_00000010_0000
03_00002400_0000  // old-path lines still in flight
04_0000000c_0000
05_00000030_0000  // long stall fills the FIFO
04_00000050_0000  // 80 reads after back-pressure
02_00000001_0001  // minimum latency, bypass path
03_0000300c_0000  // last word of a line
04_00000040_0000
05_00000003_0000
04_00000020_0000
02_00000001_0009  // random latencies
03_00fffff4_0000
04_0000001d_0000
03_00000044_0000
04_00000007_0000
05_0000000b_0000
03_7ffffff8_0000
04_00000033_0000
05_00000014_0000
04_00000021_0000
00_00000000_0000  // end of script

// File: test/ifq_tb.sv
/* testbench top, run from the project root. script and pattern key come from
   test/ifq_golden.txt, the cache model echoes each request epoch */
module ifq_tb;
    import ifq_pkg::*;

    localparam int SCRIPT_LEN = 32;

    // one command per golden file entry
    typedef enum logic [7:0] {
        OP_END      = 8'h00,
        OP_KEY      = 8'h01,
        OP_LATENCY  = 8'h02,
        OP_REDIRECT = 8'h03,
        OP_READ     = 8'h04,
        OP_STALL    = 8'h05
    } op_e;

    logic                   clk;
    logic                   arst_n;
    ifq_redirect_t          redirect;
    logic                   req_valid;
    ifq_req_t               req;
    logic                   resp_valid;
    ifq_line_t              resp_line;
    logic                   rd_en;
    logic                   empty;
    logic [IFQ_ADDR_W-1:0]  pc;
    logic [IFQ_WORD_W-1:0]  instr;

    logic [IFQ_WORD_W-1:0]  key;
    logic [55:0]            script [SCRIPT_LEN];
    int                     end_idx;
    int                     limit;
    logic                   loaded;
    int                     script_errs;
    int                     reads;
    int                     mismatches;
    int                     other_errs;

    // cache model state
    integer                 seed = 32'hd19cc91d;
    int                     lat_min;
    int                     lat_max;
    int                     cyc;
    logic [IFQ_LINE_AW-1:0] pend_line [$];
    logic                   pend_epoch [$];
    int                     pend_due [$];

    ifq_clk_gen clk_gen_i (.o_clk(clk), .o_arst_n(arst_n));

    ifq ifq_i (
        .i_clk(clk), .i_arst_n(arst_n), .i_redirect(redirect),
        .o_req_valid(req_valid), .o_req(req),
        .i_line_valid(resp_valid), .i_line(resp_line),
        .i_rd_en(rd_en), .o_empty(empty), .o_pc(pc), .o_instr(instr)
    );

    ifq_checker checker_i (
        .i_clk(clk), .i_arst_n(arst_n), .i_redirect(redirect),
        .i_rd_en(rd_en), .i_empty(empty), .i_req_valid(req_valid),
        .i_pc(pc), .i_instr(instr), .i_key(key),
        .o_reads(reads), .o_mismatches(mismatches), .o_other_errs(other_errs)
    );

    // word at byte address A holds A ^ key
    function automatic logic [IFQ_LINE_W-1:0] line_data(input logic [IFQ_LINE_AW-1:0] line);
        logic [IFQ_LINE_W-1:0] data;
        logic [IFQ_ADDR_W-1:0] addr;
        for (int w = 0; w < IFQ_WORDS; w++) begin
            addr = {line, {IFQ_OFS_W{1'b0}}} + IFQ_ADDR_W'(4 * w);
            data[w*IFQ_WORD_W +: IFQ_WORD_W] = addr ^ key;
        end
        return data;
    endfunction

    function automatic int pick_latency();
        int span;
        span = lat_max - lat_min + 1;
        return lat_min + int'($unsigned($random(seed)) % span);
    endfunction

    // capture each request mid-cycle with its own latency
    always @(negedge clk) begin
        if (arst_n && req_valid) begin
            pend_line.push_back(req.line);
            pend_epoch.push_back(req.epoch);
            pend_due.push_back(cyc + pick_latency());
        end
    end

    // answers in request order with at most one line per cycle
    always @(posedge clk) begin
        #1;
        cyc = cyc + 1;
        resp_valid = 1'b0;
        if (pend_due.size() > 0) begin
            if (pend_due[0] <= cyc) begin
                resp_valid = 1'b1;
                resp_line.data = line_data(pend_line.pop_front());
                resp_line.epoch = pend_epoch.pop_front();
                pend_due.delete(0);
            end
        end
    end

    task automatic redirect_to(input logic [IFQ_ADDR_W-1:0] target);
        redirect.valid = 1'b1;
        redirect.target = target;
        @(posedge clk);
        #1;
        redirect.valid = 1'b0;
    endtask

    // holds rd_en until count instructions went out
    task automatic read_instrs(input int count);
        int done;
        done = 0;
        rd_en = 1'b1;
        while (done < count) begin
            @(negedge clk);
            if (!empty) begin
                done++;
            end
            @(posedge clk);
            #1;
        end
        rd_en = 1'b0;
    endtask

    task automatic stall_cycles(input int cycles);
        rd_en = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // finds the end entry, takes the key and sums the command lengths
    task automatic scan_script();
        logic [55:0] cmd;
        int total;
        int idx;
        total = 0;
        idx = 0;
        end_idx = -1;
        while (end_idx < 0 && idx < SCRIPT_LEN) begin
            cmd = script[idx];
            if ($isunknown(cmd)) begin
                idx = SCRIPT_LEN;
            end else if (cmd[55:48] == OP_END) begin
                end_idx = idx;
            end else begin
                case (cmd[55:48])
                    OP_KEY: key = cmd[47:16];
                    OP_REDIRECT: total += 1;
                    OP_READ, OP_STALL: total += int'(cmd[47:16]);
                    default: ;
                endcase
                idx++;
            end
        end
        if (end_idx < 0) begin
            script_errs++;
            $display("error: golden file missing or without an end command");
        end
        limit = 8 * (total * 8 + 200);
    endtask

    task automatic run_script();
        logic [55:0] cmd;
        for (int i = 0; i < end_idx; i++) begin
            cmd = script[i];
            case (cmd[55:48])
                OP_KEY: ;
                OP_LATENCY: begin
                    if (cmd[47:16] == 0 || cmd[15:0] < cmd[47:16]) begin
                        script_errs++;
                        $display("error: bad latency range in golden file entry %0d", i);
                    end else begin
                        lat_min = int'(cmd[47:16]);
                        lat_max = int'(cmd[15:0]);
                    end
                end
                OP_REDIRECT: redirect_to(cmd[47:16]);
                OP_READ: read_instrs(int'(cmd[47:16]));
                OP_STALL: stall_cycles(int'(cmd[47:16]));
                default: begin
                    script_errs++;
                    $display("error: unknown opcode %02h in golden file entry %0d",
                             cmd[55:48], i);
                end
            endcase
        end
    endtask

    task automatic report_counts();
        $display("reads %0d, mismatches %0d, other errors %0d",
                 reads, mismatches, other_errs + script_errs);
    endtask

    initial begin
        redirect = '0;
        resp_valid = 1'b0;
        resp_line = '0;
        rd_en = 1'b0;
        key = '0;
        lat_min = 1;
        lat_max = 1;
        script_errs = 0;
        loaded = 1'b0;
        $readmemh("test/ifq_golden.txt", script);
        scan_script();
        loaded = 1'b1;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        if (end_idx >= 0) begin
            run_script();
        end
        // let the last cycle pass the checker
        repeat (4) @(posedge clk);
        #1;
        report_counts();
        if (mismatches == 0 && other_errs == 0 && script_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog limit grows with the script length
    initial begin
        wait (loaded === 1'b1);
        #(limit);
        $display("error: run did not finish within %0d time units", limit);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: test/ifq_checker.sv
/* checks every dispatched instruction against the rule instr = pc ^ key.
   redirect targets are taken as word aligned */
module ifq_checker (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  ifq_pkg::ifq_redirect_t          i_redirect,
    input  logic                            i_rd_en,
    input  logic                            i_empty,
    input  logic                            i_req_valid,
    input  logic [ifq_pkg::IFQ_ADDR_W-1:0]  i_pc,
    input  logic [ifq_pkg::IFQ_WORD_W-1:0]  i_instr,
    input  logic [ifq_pkg::IFQ_WORD_W-1:0]  i_key,
    output int                              o_reads,
    output int                              o_mismatches,
    output int                              o_other_errs
);
    import ifq_pkg::*;

    logic [IFQ_ADDR_W-1:0] exp_pc;
    logic [IFQ_WORD_W-1:0] exp_instr;
    logic                  first_cycle;
    logic                  after_redirect;

    // sampled mid-cycle, inputs only change just after the rising edge
    always @(negedge i_clk) begin
        if (!i_arst_n) begin
            exp_pc = '0;
            first_cycle = 1'b1;
            after_redirect = 1'b0;
        end else begin
            // idle right after reset, nothing requested yet
            if (first_cycle && (i_empty !== 1'b1 || i_req_valid !== 1'b0)) begin
                o_other_errs++;
                $display("error at %0t: queue not idle in the first cycle after reset",
                         $time);
            end
            // no new-path line can be back this early
            if (after_redirect && i_empty !== 1'b1) begin
                o_other_errs++;
                $display("error at %0t: o_empty low in the cycle after a redirect", $time);
            end
            first_cycle = 1'b0;
            after_redirect = i_redirect.valid;
            if (i_redirect.valid) begin
                exp_pc = {i_redirect.target[IFQ_ADDR_W-1:2], 2'b00};
            end else if (i_rd_en && !i_empty) begin
                exp_instr = exp_pc ^ i_key;
                o_reads++;
                if (i_pc !== exp_pc) begin
                    o_mismatches++;
                    $display("mismatch o_pc: got 0x%08h expected 0x%08h at %0t",
                             i_pc, exp_pc, $time);
                end
                if (i_instr !== exp_instr) begin
                    o_mismatches++;
                    $display("mismatch o_instr: got 0x%08h expected 0x%08h at %0t",
                             i_instr, exp_instr, $time);
                end
                exp_pc = exp_pc + 32'd4;
            end
        end
    end

endmodule

// File: test/ifq_clk_gen.sv
/* free running clock with period 8, reset held low for the first 10 rising edges */
module ifq_clk_gen (
    output logic o_clk,
    output logic o_arst_n
);
    // half period
    initial begin
        o_clk = 1'b0;
        forever begin
            #4 o_clk = ~o_clk;
        end
    end

    initial begin
        o_arst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        #1 o_arst_n = 1'b1;
    end

endmodule

// File: src/ifq.sv
/* instruction fetch queue top. the cache must return lines in request order,
   at most one per cycle, and never stalls a request */
module ifq (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  ifq_pkg::ifq_redirect_t          i_redirect,
    output logic                            o_req_valid,
    output ifq_pkg::ifq_req_t               o_req,
    input  logic                            i_line_valid,
    input  ifq_pkg::ifq_line_t              i_line,
    input  logic                            i_rd_en,
    output logic                            o_empty,
    output logic [ifq_pkg::IFQ_ADDR_W-1:0]  o_pc,
    output logic [ifq_pkg::IFQ_WORD_W-1:0]  o_instr
);
    import ifq_pkg::*;

    logic [IFQ_CRED_W-1:0] credit_ret;
    logic [IFQ_LINE_W-1:0] fifo_head;
    logic                  fifo_empty;
    logic                  epoch;
    logic                  pop;
    logic                  bypass_done;

    // request side
    ifq_fetch_ctrl fetch_ctrl_i (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_redirect   (i_redirect),
        .i_credit_ret (credit_ret),
        .o_req_valid  (o_req_valid),
        .o_req        (o_req),
        .o_epoch      (epoch)
    );

    // redirect doubles as the flush
    ifq_line_fifo line_fifo_i (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_line_valid  (i_line_valid),
        .i_line        (i_line),
        .i_epoch       (epoch),
        .i_flush       (i_redirect.valid),
        .i_pop         (pop),
        .i_bypass_done (bypass_done),
        .o_head        (fifo_head),
        .o_empty       (fifo_empty),
        .o_credit_ret  (credit_ret)
    );

    // dispatch side
    ifq_instr_select instr_select_i (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_redirect    (i_redirect),
        .i_rd_en       (i_rd_en),
        .i_head        (fifo_head),
        .i_fifo_empty  (fifo_empty),
        .i_line_valid  (i_line_valid),
        .i_line        (i_line),
        .i_epoch       (epoch),
        .o_pop         (pop),
        .o_bypass_done (bypass_done),
        .o_empty       (o_empty),
        .o_pc          (o_pc),
        .o_instr       (o_instr)
    );

endmodule

// File: src/ifq_instr_select.sv
/* presents one instruction per cycle from the FIFO head, or from the arriving line
   when the FIFO is empty. redirect targets are taken as word aligned */
module ifq_instr_select (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  ifq_pkg::ifq_redirect_t          i_redirect,
    input  logic                            i_rd_en,
    input  logic [ifq_pkg::IFQ_LINE_W-1:0]  i_head,
    input  logic                            i_fifo_empty,
    input  logic                            i_line_valid,
    input  ifq_pkg::ifq_line_t              i_line,
    input  logic                            i_epoch,
    output logic                            o_pop,
    output logic                            o_bypass_done,
    output logic                            o_empty,
    output logic [ifq_pkg::IFQ_ADDR_W-1:0]  o_pc,
    output logic [ifq_pkg::IFQ_WORD_W-1:0]  o_instr
);
    import ifq_pkg::*;

    logic [IFQ_ADDR_W-1:0] pc_q;
    logic [IFQ_WSEL_W-1:0] word_sel;
    logic [IFQ_LINE_W-1:0] src_line;
    ifq_src_e              src;
    logic                  arrive_ok;
    logic                  rd_ok;
    logic                  last_word;

    // arriving line usable only if it is on the current path
    assign arrive_ok = i_line_valid && (i_line.epoch == i_epoch);

    // FIFO head always wins, its line is older
    always_comb begin
        if (i_fifo_empty) begin
            src = SRC_BYPASS;
        end else begin
            src = SRC_FIFO;
        end
    end

    assign o_empty = i_fifo_empty && !arrive_ok;

    // word within the line from the PC
    assign word_sel = pc_q[IFQ_OFS_W-1:2];
    assign src_line = (src == SRC_FIFO) ? i_head : i_line.data;
    assign o_instr = src_line[word_sel*IFQ_WORD_W +: IFQ_WORD_W];
    assign o_pc = pc_q;

    assign rd_ok = i_rd_en && !o_empty;
    assign last_word = (word_sel == IFQ_WSEL_W'(IFQ_WORDS - 1));

    // line is done once its last word is read
    assign o_pop = rd_ok && last_word && (src == SRC_FIFO);
    assign o_bypass_done = rd_ok && last_word && (src == SRC_BYPASS);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= '0;
        end else if (i_redirect.valid) begin
            pc_q <= {i_redirect.target[IFQ_ADDR_W-1:2], 2'b00};
        end else if (rd_ok) begin
            pc_q <= pc_q + IFQ_ADDR_W'(4);
        end
    end

endmodule

// File: src/ifq_fetch_ctrl.sv
/* issues one line request per cycle while credits last. the epoch is one bit, so
   redirects must be far enough apart that no line from two redirects back is in flight */
module ifq_fetch_ctrl (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  ifq_pkg::ifq_redirect_t          i_redirect,
    input  logic [ifq_pkg::IFQ_CRED_W-1:0]  i_credit_ret,
    output logic                            o_req_valid,
    output ifq_pkg::ifq_req_t               o_req,
    output logic                            o_epoch
);
    import ifq_pkg::*;

    logic [IFQ_LINE_AW-1:0] next_line_q;
    logic [IFQ_LINE_AW-1:0] base_line;
    logic [IFQ_CRED_W-1:0]  credit_q;
    logic [IFQ_CRED_W-1:0]  credit_avail;
    logic                   epoch_q;
    logic                   epoch_d;
    logic                   issue;

    // a redirect replaces the sequential line address
    assign base_line = i_redirect.valid ? i_redirect.target[IFQ_ADDR_W-1:IFQ_OFS_W]
                                        : next_line_q;

    // new path gets the other epoch
    assign epoch_d = epoch_q ^ i_redirect.valid;

    // slots freed this cycle can be spent right away
    assign credit_avail = credit_q + i_credit_ret;
    assign issue = (credit_avail != '0);

    assign o_epoch = epoch_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            // fetch starts at address 0
            next_line_q <= '0;
            credit_q <= IFQ_CRED_W'(IFQ_DEPTH);
            epoch_q <= 1'b0;
            o_req_valid <= 1'b0;
        end else begin
            if (issue) begin
                next_line_q <= base_line + 1'b1;
            end else begin
                next_line_q <= base_line;
            end
            credit_q <= credit_avail - IFQ_CRED_W'(issue);
            epoch_q <= epoch_d;
            o_req_valid <= issue;
        end
    end

    // request payload, only meaningful with o_req_valid
    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_req.line <= base_line;
            o_req.epoch <= epoch_d;
        end
    end

endmodule

// File: src/ifq_line_fifo.sv
/* line FIFO, never written past full because the credits bound the lines in flight;
   a flush drops the line arriving in the same cycle and returns its credit */
module ifq_line_fifo (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_line_valid,
    input  ifq_pkg::ifq_line_t              i_line,
    input  logic                            i_epoch,
    input  logic                            i_flush,
    input  logic                            i_pop,
    input  logic                            i_bypass_done,
    output logic [ifq_pkg::IFQ_LINE_W-1:0]  o_head,
    output logic                            o_empty,
    output logic [ifq_pkg::IFQ_CRED_W-1:0]  o_credit_ret
);
    import ifq_pkg::*;

    logic [IFQ_LINE_W-1:0] mem [IFQ_DEPTH];
    logic [IFQ_PTR_W-1:0]  rd_ptr_q;
    logic [IFQ_PTR_W-1:0]  wr_ptr_q;
    logic [IFQ_CRED_W-1:0] count_q;

    logic line_current;
    logic line_stale;
    logic wr_en;
    logic rd_en;
    logic bypass_free;

    // arriving line belongs to the current fetch path
    assign line_current = i_line_valid && (i_line.epoch == i_epoch);
    assign line_stale = i_line_valid && (i_line.epoch != i_epoch);

    // fully used through the bypass, so it never takes a slot
    assign bypass_free = line_current && i_bypass_done;

    assign wr_en = line_current && !i_bypass_done && !i_flush;
    assign rd_en = i_pop && !o_empty && !i_flush;

    assign o_empty = (count_q == '0);
    assign o_head = mem[rd_ptr_q];

    // slots freed this cycle go back to the fetch controller
    always_comb begin
        if (i_flush) begin
            o_credit_ret = count_q + IFQ_CRED_W'(i_line_valid);
        end else begin
            o_credit_ret = IFQ_CRED_W'(rd_en)
                         + IFQ_CRED_W'(line_stale)
                         + IFQ_CRED_W'(bypass_free);
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q <= '0;
        end else if (i_flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + IFQ_CRED_W'(wr_en) - IFQ_CRED_W'(rd_en);
        end
    end

    // line storage
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= i_line.data;
        end
    end

endmodule

// File: src/ifq_pkg.sv
/* shared sizes and types of the fetch queue. IFQ_DEPTH must be a power of two
   so that the FIFO pointers wrap on their own */
package ifq_pkg;

    // line FIFO depth, also the credit count after reset
    localparam int IFQ_DEPTH = 4;
    localparam int IFQ_LINE_W = 128;
    localparam int IFQ_ADDR_W = 32;
    localparam int IFQ_WORD_W = 32;

    localparam int IFQ_WORDS = IFQ_LINE_W / IFQ_WORD_W;
    // byte offset bits inside one cache line
    localparam int IFQ_OFS_W = $clog2(IFQ_LINE_W / 8);
    localparam int IFQ_WSEL_W = $clog2(IFQ_WORDS);
    localparam int IFQ_LINE_AW = IFQ_ADDR_W - IFQ_OFS_W;

    // must hold the values 0 to IFQ_DEPTH
    localparam int IFQ_CRED_W = $clog2(IFQ_DEPTH + 1);
    localparam int IFQ_PTR_W = $clog2(IFQ_DEPTH);

    // line request to the instruction cache
    typedef struct packed {
        logic [IFQ_LINE_AW-1:0] line;
        logic                   epoch;
    } ifq_req_t;

    // line returned by the cache, epoch echoed from the request
    typedef struct packed {
        logic [IFQ_LINE_W-1:0] data;
        logic                  epoch;
    } ifq_line_t;

    // jump or taken branch from execute
    typedef struct packed {
        logic                  valid;
        logic [IFQ_ADDR_W-1:0] target;
    } ifq_redirect_t;

    // where the dispatched instruction comes from
    typedef enum logic {
        SRC_FIFO,
        SRC_BYPASS
    } ifq_src_e;

endpackage
